// ==== hw/fetch_pkg.sv ====
// Fetch address, instruction and line types shared by the fetch front end and the icache
package fetch_pkg;

    // Physical fetch address width
    localparam int ADDR_W = 32;

    // Set index field sized for the largest cache, narrower caches use the low bits
    localparam int INDEX_W = 6;

    // Words per cache line
    localparam int LINE_WORDS = 4;

    // One fetch address
    typedef logic [ADDR_W-1:0] addr_t;

    // One instruction word
    typedef logic [31:0] instr_t;

    // One 128-bit line, word 0 in the low bits
    typedef logic [LINE_WORDS*32-1:0] icache_line_t;

    // Fetch address seen raw or split into cache fields
    typedef union packed {
        addr_t raw;
        struct packed {
            logic [ADDR_W-INDEX_W-5:0] tag;
            logic [INDEX_W-1:0]        index;
            // Word within the line, address bits 3:2
            logic [1:0]                word;
            logic [1:0]                byte_off;
        } f;
    } fetch_addr_u;

endpackage

// ==== hw/icache_pkg.sv ====
// Instruction cache organization constants and FSM state types for controller and line buffer
package icache_pkg;

    // Largest set count the index field of the fetch address can hold
    localparam int MAX_SETS = 2 ** fetch_pkg::INDEX_W;

    // Stored tag is the whole line address
    // Keeps the compare exact for any set count up to MAX_SETS
    localparam int TAG_W = fetch_pkg::ADDR_W - 4;

    // Cache controller states
    typedef enum logic [1:0] {
        // Waiting for a request, only state with ready high
        Idle,
        // Array output valid, tag compare
        Lookup,
        // Four single reads on Wishbone
        Refill,
        // One-cycle response to the line buffer
        Respond
    } icache_state_t;

    // Line buffer request states
    typedef enum logic [1:0] {
        ResetState,
        NoReq,
        ReqValid,
        Replay
    } ifc_state_t;

endpackage

// ==== hw/icache_interface.sv ====
// Line buffer between fetch stage and icache, requests a line only when the fetch leaves it
`timescale 1ns/1ns

module icache_interface (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    // Fetch stage side
    input  logic                     fetch_req_valid_i,
    input  fetch_pkg::addr_t         fetch_vaddr_i,
    input  logic                     fetch_invalidate_i,
    output logic                     fetch_valid_o,
    output fetch_pkg::instr_t        fetch_instr_o,
    output logic                     fetch_fault_o,
    // Cache request
    input  logic                     icache_req_ready_i,
    output logic                     icache_req_valid_o,
    output fetch_pkg::addr_t         icache_req_addr_o,
    output logic                     icache_invalidate_o,
    // Cache response, one cycle wide
    input  logic                     icache_resp_valid_i,
    input  fetch_pkg::addr_t         icache_resp_addr_i,
    input  fetch_pkg::icache_line_t  icache_resp_line_i,
    input  logic                     icache_resp_fault_i
);

    icache_pkg::ifc_state_t  state_q, state_d;
    fetch_pkg::fetch_addr_u  fetch_fa, resp_fa, buf_addr_q, req_addr_q;
    fetch_pkg::icache_line_t buf_line_q;
    fetch_pkg::icache_line_t line_sel;
    logic                    buf_valid_q;
    logic                    buffer_miss;
    logic                    resp_match;
    logic                    pending;
    logic                    need;
    logic                    load;

    // Same line when everything above the word offset agrees
    function automatic logic same_line(fetch_pkg::fetch_addr_u a, fetch_pkg::fetch_addr_u b);
        return {a.f.tag, a.f.index} == {b.f.tag, b.f.index};
    endfunction

    assign fetch_fa.raw = fetch_vaddr_i;
    assign resp_fa.raw  = icache_resp_addr_i;

    // Buffer miss on empty buffer or another line
    assign buffer_miss = !buf_valid_q || !same_line(buf_addr_q, fetch_fa);
    // Responses for other lines are stale and ignored
    assign resp_match  = icache_resp_valid_i && same_line(resp_fa, fetch_fa);
    // Request already in flight for the current line
    assign pending     = (state_q == icache_pkg::ReqValid) && same_line(req_addr_q, fetch_fa);
    assign need        = fetch_req_valid_i && buffer_miss && !resp_match && !pending &&
                         (state_q != icache_pkg::ResetState);
    // Faulting lines never enter the buffer
    assign load        = resp_match && !icache_resp_fault_i;

    always_comb begin
        state_d            = state_q;
        icache_req_valid_o = 1'b0;
        case (state_q)
            icache_pkg::ResetState: begin
                state_d = icache_pkg::NoReq;
            end
            default: begin
                if (resp_match) begin
                    state_d = icache_pkg::NoReq;
                end else if (pending) begin
                    state_d = icache_pkg::ReqValid;
                end else if (need) begin
                    // Cache busy with an older line, wait and issue again in Replay
                    icache_req_valid_o = icache_req_ready_i;
                    state_d = icache_req_ready_i ? icache_pkg::ReqValid : icache_pkg::Replay;
                end else begin
                    state_d = icache_pkg::NoReq;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= icache_pkg::ResetState;
            buf_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Invalidate beats a response landing in the same cycle
            if (fetch_invalidate_i) begin
                buf_valid_q <= 1'b0;
            end else if (load) begin
                buf_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            buf_line_q <= icache_resp_line_i;
            buf_addr_q <= resp_fa;
        end
        if (icache_req_valid_o) begin
            req_addr_q <= fetch_fa;
        end
    end

    // Word served from the response in its cycle, otherwise from the buffer
    assign line_sel      = resp_match ? icache_resp_line_i : buf_line_q;
    assign fetch_instr_o = line_sel[fetch_fa.f.word*32 +: 32];

    assign fetch_valid_o = fetch_req_valid_i && (state_q != icache_pkg::ResetState) &&
                           (!buffer_miss || resp_match);
    // A buffer miss served in this cycle came from the response
    assign fetch_fault_o = fetch_valid_o && buffer_miss && icache_resp_fault_i;

    assign icache_req_addr_o   = fetch_vaddr_i;
    assign icache_invalidate_o = fetch_invalidate_i;

    // Controller answers the request handed over last
    a_resp_for_last_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        icache_resp_valid_i |-> (icache_resp_addr_i == req_addr_q.raw));

endmodule

// ==== hw/icache_array.sv ====
// Direct-mapped icache storage with registered read, refill write and flash invalidate
`timescale 1ns/1ns

module icache_array #(
    parameter  int NUM_SETS = 16,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    // Read port, data one cycle after the index
    input  logic [IDX_W-1:0]              rd_index_i,
    output logic                          rd_valid_o,
    output logic [icache_pkg::TAG_W-1:0]  rd_tag_o,
    output fetch_pkg::icache_line_t       rd_line_o,
    // Refill write port
    input  logic                          wr_en_i,
    input  logic [IDX_W-1:0]              wr_index_i,
    input  logic [icache_pkg::TAG_W-1:0]  wr_tag_i,
    input  fetch_pkg::icache_line_t       wr_line_i,
    // Clears every valid bit
    input  logic                          flush_i
);

    logic [NUM_SETS-1:0]          valid_q;
    logic [icache_pkg::TAG_W-1:0] tag_mem [NUM_SETS];
    fetch_pkg::icache_line_t      data_mem [NUM_SETS];

    // Set count must fit the index field of the fetch address
    initial begin
        assert (NUM_SETS >= 2 && NUM_SETS <= icache_pkg::MAX_SETS)
            else $fatal(1, "icache_array: NUM_SETS out of range");
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q    <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            // Flush wins over a refill write
            if (flush_i) begin
                valid_q <= '0;
            end else if (wr_en_i) begin
                valid_q[wr_index_i] <= 1'b1;
            end
            rd_valid_o <= valid_q[rd_index_i] && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i && !flush_i) begin
            tag_mem[wr_index_i]  <= wr_tag_i;
            data_mem[wr_index_i] <= wr_line_i;
        end
        // Read before write on the same set
        rd_tag_o  <= tag_mem[rd_index_i];
        rd_line_o <= data_mem[rd_index_i];
    end

endmodule

// ==== hw/icache_ctrl.sv ====
// Icache lookup and four-beat Wishbone classic refill, answers the line buffer with a pulse
`timescale 1ns/1ns

module icache_ctrl #(
    parameter  int NUM_SETS = 16,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    // Request from the line buffer
    input  logic                          req_valid_i,
    input  fetch_pkg::addr_t              req_addr_i,
    input  logic                          invalidate_i,
    output logic                          req_ready_o,
    // Response, held one cycle
    output logic                          resp_valid_o,
    output fetch_pkg::addr_t              resp_addr_o,
    output fetch_pkg::icache_line_t       resp_line_o,
    output logic                          resp_fault_o,
    // Array ports
    output logic [IDX_W-1:0]              rd_index_o,
    input  logic                          rd_valid_i,
    input  logic [icache_pkg::TAG_W-1:0]  rd_tag_i,
    input  fetch_pkg::icache_line_t       rd_line_i,
    output logic                          wr_en_o,
    output logic [IDX_W-1:0]              wr_index_o,
    output logic [icache_pkg::TAG_W-1:0]  wr_tag_o,
    output fetch_pkg::icache_line_t       wr_line_o,
    output logic                          flush_o,
    // Wishbone classic master, reads only
    output logic                          wb_cyc_o,
    output logic                          wb_stb_o,
    output fetch_pkg::addr_t              wb_adr_o,
    input  fetch_pkg::instr_t             wb_dat_i,
    input  logic                          wb_ack_i,
    input  logic                          wb_err_i
);

    icache_pkg::icache_state_t state_q, state_d;
    fetch_pkg::fetch_addr_u    in_fa, req_q, wb_fa;
    fetch_pkg::icache_line_t   line_q;
    logic [1:0]                beat_q;
    logic                      fault_q;
    logic                      hit;
    logic                      last_ack;

    assign in_fa.raw   = req_addr_i;
    // Array reads the incoming index so its output is ready in Lookup
    assign rd_index_o  = in_fa.f.index[IDX_W-1:0];
    assign req_ready_o = (state_q == icache_pkg::Idle);
    assign hit         = rd_valid_i && (rd_tag_i == {req_q.f.tag, req_q.f.index});
    assign last_ack    = wb_ack_i && !wb_err_i && (beat_q == 2'd3);

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::Idle:    if (req_valid_i) state_d = icache_pkg::Lookup;
            icache_pkg::Lookup:  state_d = hit ? icache_pkg::Respond : icache_pkg::Refill;
            // Error ends the refill at once
            icache_pkg::Refill:  if (wb_err_i || last_ack) state_d = icache_pkg::Respond;
            default:             state_d = icache_pkg::Idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= icache_pkg::Idle;
            beat_q  <= 2'd0;
            fault_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == icache_pkg::Lookup) begin
                beat_q  <= 2'd0;
                fault_q <= 1'b0;
            end else if (state_q == icache_pkg::Refill) begin
                if (wb_err_i) begin
                    fault_q <= 1'b1;
                end else if (wb_ack_i) begin
                    beat_q <= beat_q + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= in_fa;
        end
        if (state_q == icache_pkg::Lookup && hit) begin
            line_q <= rd_line_i;
        end else if (state_q == icache_pkg::Refill && wb_ack_i && !wb_err_i) begin
            line_q[beat_q*32 +: 32] <= wb_dat_i;
        end
    end

    // Beat address walks words 0 to 3 of the line
    always_comb begin
        wb_fa            = req_q;
        wb_fa.f.word     = beat_q;
        wb_fa.f.byte_off = 2'b00;
    end

    assign wb_cyc_o = (state_q == icache_pkg::Refill);
    assign wb_stb_o = (state_q == icache_pkg::Refill);
    assign wb_adr_o = wb_fa.raw;

    // Last word goes straight from the bus into the array
    assign wr_en_o    = (state_q == icache_pkg::Refill) && last_ack;
    assign wr_index_o = req_q.f.index[IDX_W-1:0];
    assign wr_tag_o   = {req_q.f.tag, req_q.f.index};
    assign wr_line_o  = {wb_dat_i, line_q[3*32-1:0]};
    assign flush_o    = invalidate_i;

    assign resp_valid_o = (state_q == icache_pkg::Respond);
    assign resp_addr_o  = req_q.raw;
    assign resp_line_o  = line_q;
    assign resp_fault_o = fault_q;

    // Classic master holds strobe and address until ack or err
    a_adr_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (wb_stb_o && !wb_ack_i && !wb_err_i) |=> (wb_stb_o && $stable(wb_adr_o)));

    // Line written on the last beat is the line handed to the buffer
    a_refill_resp_line: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wr_en_o |=> (resp_valid_o && !resp_fault_o && (resp_line_o == $past(wr_line_o))));

endmodule

// ==== hw/fetch_frontend.sv ====
// Instruction fetch front end top, line buffer and direct-mapped icache on a Wishbone port
`timescale 1ns/1ns

module fetch_frontend #(
    parameter  int NUM_SETS = 16,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    // Fetch stage
    input  logic               fetch_req_valid_i,
    input  fetch_pkg::addr_t   fetch_vaddr_i,
    input  logic               fetch_invalidate_i,
    output logic               fetch_valid_o,
    output fetch_pkg::instr_t  fetch_instr_o,
    output logic               fetch_fault_o,
    // Wishbone classic master
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic               wb_we_o,
    output fetch_pkg::addr_t   wb_adr_o,
    output logic [3:0]         wb_sel_o,
    input  fetch_pkg::instr_t  wb_dat_i,
    input  logic               wb_ack_i,
    input  logic               wb_err_i
);

    logic                         req_valid, req_ready, invalidate;
    fetch_pkg::addr_t             req_addr, resp_addr;
    logic                         resp_valid, resp_fault;
    fetch_pkg::icache_line_t      resp_line, rd_line, wr_line;
    logic [IDX_W-1:0]             rd_index, wr_index;
    logic [icache_pkg::TAG_W-1:0] rd_tag, wr_tag;
    logic                         rd_valid, wr_en, flush;

    // Instruction fetch only reads whole words
    assign wb_we_o  = 1'b0;
    assign wb_sel_o = 4'hf;

    icache_interface u_ifc (
        .clk_i, .rstn_i, .fetch_req_valid_i, .fetch_vaddr_i, .fetch_invalidate_i,
        .fetch_valid_o, .fetch_instr_o, .fetch_fault_o,
        .icache_req_ready_i(req_ready), .icache_req_valid_o(req_valid),
        .icache_req_addr_o(req_addr), .icache_invalidate_o(invalidate),
        .icache_resp_valid_i(resp_valid), .icache_resp_addr_i(resp_addr),
        .icache_resp_line_i(resp_line), .icache_resp_fault_i(resp_fault)
    );

    icache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (
        .clk_i, .rstn_i, .req_valid_i(req_valid), .req_addr_i(req_addr),
        .invalidate_i(invalidate), .req_ready_o(req_ready), .resp_valid_o(resp_valid),
        .resp_addr_o(resp_addr), .resp_line_o(resp_line), .resp_fault_o(resp_fault),
        .rd_index_o(rd_index), .rd_valid_i(rd_valid), .rd_tag_i(rd_tag), .rd_line_i(rd_line),
        .wr_en_o(wr_en), .wr_index_o(wr_index), .wr_tag_o(wr_tag), .wr_line_o(wr_line),
        .flush_o(flush), .wb_cyc_o, .wb_stb_o, .wb_adr_o, .wb_dat_i, .wb_ack_i, .wb_err_i
    );

    icache_array #(.NUM_SETS(NUM_SETS)) u_array (
        .clk_i, .rstn_i, .rd_index_i(rd_index), .rd_valid_o(rd_valid), .rd_tag_o(rd_tag),
        .rd_line_o(rd_line), .wr_en_i(wr_en), .wr_index_i(wr_index), .wr_tag_i(wr_tag),
        .wr_line_i(wr_line), .flush_i(flush)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
// Testbench clock source and power-on reset, instantiated once by the fetch front end testbench
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rstn_o
);

    // Free running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset low for the first cycles, released on a falling edge
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

// ==== verif/tb_fetch_frontend.sv ====
// Testbench for the fetch front end, walks a fetch table against a Wishbone memory model
`timescale 1ns/1ns

module tb_fetch_frontend;

    localparam int          NUM_SETS     = 16;
    localparam int          RESET_CYCLES = 8;
    localparam int          NUM_ROWS     = 13;
    localparam int          ROW_CYCLES   = 40;
    localparam int          TIMEOUT      = NUM_ROWS * ROW_CYCLES + RESET_CYCLES;
    localparam logic [31:0] MEM_KEY      = 32'h1057265e;
    localparam int unsigned SEED         = 32'h1057265e;

    logic        clk_i;
    logic        rstn_i;
    logic        fetch_req_valid_i;
    logic [31:0] fetch_vaddr_i;
    logic        fetch_invalidate_i;
    logic        fetch_valid_o;
    logic [31:0] fetch_instr_o;
    logic        fetch_fault_o;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic        wb_we_o;
    logic [31:0] wb_adr_o;
    logic [3:0]  wb_sel_o;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;
    logic        wb_err_i;

    // Table columns: fetch address, invalidate before it, expected fault, expected bus beats
    logic [31:0] row_addr  [NUM_ROWS];
    logic        row_inval [NUM_ROWS];
    logic        row_fault [NUM_ROWS];
    int          row_beats [NUM_ROWS];
    int          n_rows    = 0;

    // Wishbone beats answered by the memory model, ack or err
    int          beat_cnt  = 0;
    int          cycle_cnt = 0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) u_clk (
        .clk_o(clk_i), .rstn_o(rstn_i)
    );

    fetch_frontend #(.NUM_SETS(NUM_SETS)) u_dut (
        .clk_i, .rstn_i, .fetch_req_valid_i, .fetch_vaddr_i, .fetch_invalidate_i,
        .fetch_valid_o, .fetch_instr_o, .fetch_fault_o,
        .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o,
        .wb_dat_i, .wb_ack_i, .wb_err_i
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp)
            else report_failure($sformatf("[FAIL] t=%0t %s expected 0x%08h got 0x%08h",
                                          $time, name, exp, got));
    endtask

    task automatic add_row(input logic [31:0] addr, input logic inval, input logic fault,
                           input int beats);
        row_addr[n_rows]  = addr;
        row_inval[n_rows] = inval;
        row_fault[n_rows] = fault;
        row_beats[n_rows] = beats;
        n_rows++;
    endtask

    // Wishbone slave, word at A is A xor key, bit 31 set answers err
    initial begin : wb_memory_model
        int unsigned wait_cnt;
        wb_ack_i = 1'b0;
        wb_err_i = 1'b0;
        wb_dat_i = '0;
        void'($urandom(SEED));
        wait_cnt = $urandom % 4;
        forever begin
            @(negedge clk_i);
            if (wb_ack_i || wb_err_i) begin
                // Beat taken on the last rising edge, new random delay
                wb_ack_i = 1'b0;
                wb_err_i = 1'b0;
                wait_cnt = $urandom % 4;
            end else if (wb_cyc_o && wb_stb_o) begin
                // Fetch only ever reads whole words
                check_value("wb_we_o", 32'(1'b0), 32'(wb_we_o));
                check_value("wb_sel_o", 32'(4'hf), 32'(wb_sel_o));
                if (wait_cnt != 0) begin
                    wait_cnt--;
                end else if (wb_adr_o[31]) begin
                    wb_err_i = 1'b1;
                    beat_cnt++;
                end else begin
                    wb_ack_i = 1'b1;
                    wb_dat_i = wb_adr_o ^ MEM_KEY;
                    beat_cnt++;
                end
            end
        end
    end

    // Run limit from the table length
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            report_failure($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT));
        end
    end

    initial begin : stimulus
        int base;
        int waited;
        fetch_req_valid_i  = 1'b0;
        fetch_vaddr_i      = '0;
        fetch_invalidate_i = 1'b0;
        // Cold miss, then words of the same line from the buffer
        add_row(32'h0000_1000, 1'b0, 1'b0, 4);
        add_row(32'h0000_1004, 1'b0, 1'b0, 0);
        add_row(32'h0000_100c, 1'b0, 1'b0, 0);
        add_row(32'h0000_1008, 1'b0, 1'b0, 0);
        // Second line, then a cache hit on the first
        add_row(32'h0000_2010, 1'b0, 1'b0, 4);
        add_row(32'h0000_1004, 1'b0, 1'b0, 0);
        // Same set 0, other tag, evicts and comes back
        add_row(32'h0000_3000, 1'b0, 1'b0, 4);
        add_row(32'h0000_1008, 1'b0, 1'b0, 4);
        add_row(32'h0000_2014, 1'b0, 1'b0, 0);
        // Invalidate clears buffer and cache
        add_row(32'h0000_2018, 1'b1, 1'b0, 4);
        // Err on the first beat, line never cached
        add_row(32'h8000_0040, 1'b0, 1'b1, 1);
        add_row(32'h8000_0040, 1'b0, 1'b1, 1);
        add_row(32'h0000_100c, 1'b0, 1'b0, 4);

        wait (rstn_i);
        @(negedge clk_i);
        check_value("wb_stb_o", 32'(1'b0), 32'(wb_stb_o));
        check_value("wb_cyc_o", 32'(1'b0), 32'(wb_cyc_o));

        for (int i = 0; i < n_rows; i++) begin
            if (row_inval[i]) begin
                // One-cycle pulse with no fetch pending
                fetch_req_valid_i  = 1'b0;
                fetch_invalidate_i = 1'b1;
                @(negedge clk_i);
                fetch_invalidate_i = 1'b0;
            end
            base              = beat_cnt;
            fetch_req_valid_i = 1'b1;
            fetch_vaddr_i     = row_addr[i];
            waited            = 0;
            do begin
                @(negedge clk_i);
                waited++;
                if (waited > ROW_CYCLES) begin
                    report_failure($sformatf("No fetch_valid_o for address 0x%08h", row_addr[i]));
                end
            end while (!fetch_valid_o);
            check_value("fetch_fault_o", 32'(row_fault[i]), 32'(fetch_fault_o));
            if (!row_fault[i]) begin
                check_value("fetch_instr_o", {row_addr[i][31:2], 2'b00} ^ MEM_KEY, fetch_instr_o);
            end
            check_value("wishbone beat count", 32'(row_beats[i]), 32'(beat_cnt - base));
            // Address held through the edge that ends the valid cycle
            @(negedge clk_i);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== fetch_frontend.f ====
hw/fetch_pkg.sv
hw/icache_pkg.sv
hw/icache_interface.sv
hw/icache_array.sv
hw/icache_ctrl.sv
hw/fetch_frontend.sv
verif/tb_clock_gen.sv
verif/tb_fetch_frontend.sv

// ==== run.sh ====
#!/bin/sh
# Builds the fetch front end testbench with Verilator and runs it
# Exit status is nonzero when the build fails or the testbench reports a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_fetch_frontend \
    -f fetch_frontend.f \
    -o sim_fetch_frontend
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_fetch_frontend
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

echo "Simulation finished cleanly"
exit 0
